// File: bp_pkg.sv
package bp_pkg;

    // Two-bit saturating counter, upper bit means taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } bp_counter_e;

    // Default geometry
    localparam int PC_W_DEFAULT       = 32;
    localparam int HIST_IDX_W_DEFAULT = 8;   // 256 per-branch histories
    localparam int HIST_W_DEFAULT     = 10;  // 1024 counters
    localparam int BTB_IDX_W_DEFAULT  = 7;   // 128 target entries

endpackage

// File: bp_history_table.sv
module bp_history_table import bp_pkg::*; #(
    parameter int HIST_IDX_W = HIST_IDX_W_DEFAULT,
    parameter int HIST_W     = HIST_W_DEFAULT
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic [HIST_IDX_W-1:0] rd_idx_i,
    output logic [HIST_W-1:0]     rd_hist_o,

    input  logic                  wr_en_i,
    input  logic [HIST_IDX_W-1:0] wr_idx_i,
    input  logic                  wr_taken_i,
    output logic [HIST_W-1:0]     wr_old_hist_o
);

    localparam int DEPTH = 2 ** HIST_IDX_W;

    logic [HIST_W-1:0] hist_q [DEPTH];

    assign rd_hist_o     = hist_q[rd_idx_i];
    assign wr_old_hist_o = hist_q[wr_idx_i];  // Pre-write value, feeds the counter index

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            // Oldest outcome drops off the top
            hist_q[wr_idx_i] <= {wr_old_hist_o[HIST_W-2:0], wr_taken_i};
        end
    end

endmodule

// File: bp_counter_table.sv
module bp_counter_table import bp_pkg::*; #(
    parameter int HIST_W = HIST_W_DEFAULT
) (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic [HIST_W-1:0] rd_idx_i,
    output logic              rd_taken_o,

    input  logic              wr_en_i,
    input  logic [HIST_W-1:0] wr_idx_i,
    input  logic              wr_taken_i
);

    localparam int DEPTH = 2 ** HIST_W;

    bp_counter_e ctr_q [DEPTH];
    bp_counter_e ctr_next;

    // Saturating step toward the resolved outcome
    function automatic bp_counter_e ctr_step(input bp_counter_e cur, input logic taken);
        bp_counter_e nxt;
        case (cur)
            strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
            weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
            strong_taken:     nxt = taken ? strong_taken   : weak_taken;
            default:          nxt = strong_not_taken;
        endcase
        return nxt;
    endfunction

    assign ctr_next   = ctr_step(ctr_q[wr_idx_i], wr_taken_i);
    assign rd_taken_o = ctr_q[rd_idx_i][1];

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= strong_not_taken;
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx_i] <= ctr_next;
        end
    end

endmodule

// File: bp_target_buffer.sv
module bp_target_buffer import bp_pkg::*; #(
    parameter int PC_W      = PC_W_DEFAULT,
    parameter int BTB_IDX_W = BTB_IDX_W_DEFAULT
) (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic [PC_W-1:0] rd_pc_i,
    output logic            rd_hit_o,
    output logic [PC_W-1:0] rd_target_o,

    input  logic            wr_en_i,
    input  logic [PC_W-1:0] wr_pc_i,
    input  logic [PC_W-1:0] wr_target_i
);

    localparam int DEPTH = 2 ** BTB_IDX_W;
    localparam int TAG_W = PC_W - 2;  // Full word address

    logic [TAG_W-1:0]     tag_q    [DEPTH];
    logic [PC_W-1:0]      target_q [DEPTH];
    logic [DEPTH-1:0]     valid_q;

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;

    // Index skips the byte offset within a word
    assign rd_idx = rd_pc_i[BTB_IDX_W+1:2];
    assign wr_idx = wr_pc_i[BTB_IDX_W+1:2];

    assign rd_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_pc_i[PC_W-1:2]);
    assign rd_target_o = target_q[rd_idx];

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_pc_i[PC_W-1:2];
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// File: bp_lookup_stage.sv
module bp_lookup_stage import bp_pkg::*; #(
    parameter int PC_W       = PC_W_DEFAULT,
    parameter int HIST_IDX_W = HIST_IDX_W_DEFAULT,
    parameter int HIST_W     = HIST_W_DEFAULT
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  lookup_valid_i,
    input  logic [PC_W-1:0]       lookup_pc_i,
    output logic                  lookup_ready_o,

    output logic                  pred_valid_o,
    output logic [PC_W-1:0]       pred_pc_o,
    output logic                  pred_taken_o,
    output logic [PC_W-1:0]       pred_target_o,
    input  logic                  pred_ready_i,

    output logic [HIST_IDX_W-1:0] hist_idx_o,
    input  logic [HIST_W-1:0]     hist_i,

    output logic [PC_W-1:0]       btb_pc_o,
    input  logic                  btb_hit_i,
    input  logic [PC_W-1:0]       btb_target_i,

    output logic [HIST_W-1:0]     ctr_idx_o,
    input  logic                  ctr_taken_i
);

    logic              s1_valid_q;
    logic [PC_W-1:0]   s1_pc_q;
    logic [HIST_W-1:0] s1_hist_q;
    logic              s1_hit_q;
    logic [PC_W-1:0]   s1_target_q;

    logic              s2_valid_q;
    logic [PC_W-1:0]   s2_pc_q;
    logic [HIST_W-1:0] s2_hist_q;
    logic              s2_hit_q;
    logic [PC_W-1:0]   s2_target_q;

    logic              s1_accept;
    logic              s2_accept;

    // Accept-ready chain, a stage takes new data when empty or draining
    assign s2_accept      = !s2_valid_q || pred_ready_i;
    assign s1_accept      = !s1_valid_q || s2_accept;
    assign lookup_ready_o = s1_accept;

    // Table reads in the acceptance cycle
    assign hist_idx_o = lookup_pc_i[HIST_IDX_W+1:2];
    assign btb_pc_o   = lookup_pc_i;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_accept) s1_valid_q <= lookup_valid_i;
            if (s2_accept) s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_accept && lookup_valid_i) begin
            s1_pc_q     <= lookup_pc_i;
            s1_hist_q   <= hist_i;
            s1_hit_q    <= btb_hit_i;
            s1_target_q <= btb_target_i;
        end
        if (s2_accept && s1_valid_q) begin
            s2_pc_q     <= s1_pc_q;
            s2_hist_q   <= s1_hist_q;
            s2_hit_q    <= s1_hit_q;
            s2_target_q <= s1_target_q;
        end
    end

    assign ctr_idx_o = s2_hist_q;  // Counter read in stage 2

    // Taken needs both a leaning counter and a tag hit
    assign pred_valid_o  = s2_valid_q;
    assign pred_pc_o     = s2_pc_q;
    assign pred_taken_o  = ctr_taken_i && s2_hit_q;
    assign pred_target_o = pred_taken_o ? s2_target_q : s2_pc_q + PC_W'(4);

endmodule

// File: bp_update_stage.sv
module bp_update_stage import bp_pkg::*; #(
    parameter int PC_W       = PC_W_DEFAULT,
    parameter int HIST_IDX_W = HIST_IDX_W_DEFAULT,
    parameter int HIST_W     = HIST_W_DEFAULT
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  resolve_valid_i,
    input  logic [PC_W-1:0]       resolve_pc_i,
    input  logic                  resolve_taken_i,
    input  logic [PC_W-1:0]       resolve_target_i,

    output logic                  wr_en_o,
    output logic [PC_W-1:0]       wr_pc_o,
    output logic [PC_W-1:0]       wr_target_o,
    output logic                  wr_taken_o,

    output logic [HIST_IDX_W-1:0] hist_wr_idx_o,
    output logic [HIST_W-1:0]     ctr_wr_idx_o,
    input  logic [HIST_W-1:0]     old_hist_i
);

    logic            upd_valid_q;
    logic [PC_W-1:0] upd_pc_q;
    logic            upd_taken_q;
    logic [PC_W-1:0] upd_target_q;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= resolve_valid_i;  // No back-pressure
        end
    end

    always_ff @(posedge clk_i) begin
        if (resolve_valid_i) begin
            upd_pc_q     <= resolve_pc_i;
            upd_taken_q  <= resolve_taken_i;
            upd_target_q <= resolve_target_i;
        end
    end

    // One write strobe for all three tables
    assign wr_en_o       = upd_valid_q;
    assign wr_pc_o       = upd_pc_q;
    assign wr_target_o   = upd_target_q;
    assign wr_taken_o    = upd_taken_q;
    assign hist_wr_idx_o = upd_pc_q[HIST_IDX_W+1:2];

    // Counter trained at the history seen before this outcome
    assign ctr_wr_idx_o = old_hist_i;

endmodule

// File: branch_predictor.sv
module branch_predictor import bp_pkg::*; #(
    parameter int PC_W       = PC_W_DEFAULT,
    parameter int HIST_IDX_W = HIST_IDX_W_DEFAULT,
    parameter int HIST_W     = HIST_W_DEFAULT,
    parameter int BTB_IDX_W  = BTB_IDX_W_DEFAULT
) (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            lookup_valid_i,
    input  logic [PC_W-1:0] lookup_pc_i,
    output logic            lookup_ready_o,

    output logic            pred_valid_o,
    output logic [PC_W-1:0] pred_pc_o,
    output logic            pred_taken_o,
    output logic [PC_W-1:0] pred_target_o,
    input  logic            pred_ready_i,

    input  logic            resolve_valid_i,
    input  logic [PC_W-1:0] resolve_pc_i,
    input  logic            resolve_taken_i,
    input  logic [PC_W-1:0] resolve_target_i
);

    // Lookup side
    logic [HIST_IDX_W-1:0] hist_rd_idx;
    logic [HIST_W-1:0]     hist_rd;
    logic [PC_W-1:0]       btb_rd_pc;
    logic                  btb_hit;
    logic [PC_W-1:0]       btb_target;
    logic [HIST_W-1:0]     ctr_rd_idx;
    logic                  ctr_taken;

    // Update side
    logic                  wr_en;
    logic [PC_W-1:0]       wr_pc;
    logic [PC_W-1:0]       wr_target;
    logic                  wr_taken;
    logic [HIST_IDX_W-1:0] hist_wr_idx;
    logic [HIST_W-1:0]     ctr_wr_idx;
    logic [HIST_W-1:0]     old_hist;

    bp_history_table #(
        .HIST_IDX_W(HIST_IDX_W),
        .HIST_W    (HIST_W)
    ) history0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rd_idx_i     (hist_rd_idx),
        .rd_hist_o    (hist_rd),
        .wr_en_i      (wr_en),
        .wr_idx_i     (hist_wr_idx),
        .wr_taken_i   (wr_taken),
        .wr_old_hist_o(old_hist)
    );

    bp_counter_table #(
        .HIST_W(HIST_W)
    ) counter0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_idx_i  (ctr_rd_idx),
        .rd_taken_o(ctr_taken),
        .wr_en_i   (wr_en),
        .wr_idx_i  (ctr_wr_idx),
        .wr_taken_i(wr_taken)
    );

    bp_target_buffer #(
        .PC_W     (PC_W),
        .BTB_IDX_W(BTB_IDX_W)
    ) btb0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_pc_i    (btb_rd_pc),
        .rd_hit_o   (btb_hit),
        .rd_target_o(btb_target),
        .wr_en_i    (wr_en),
        .wr_pc_i    (wr_pc),
        .wr_target_i(wr_target)
    );

    bp_lookup_stage #(
        .PC_W      (PC_W),
        .HIST_IDX_W(HIST_IDX_W),
        .HIST_W    (HIST_W)
    ) lookup0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_valid_i(lookup_valid_i),
        .lookup_pc_i   (lookup_pc_i),
        .lookup_ready_o(lookup_ready_o),
        .pred_valid_o  (pred_valid_o),
        .pred_pc_o     (pred_pc_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .pred_ready_i  (pred_ready_i),
        .hist_idx_o    (hist_rd_idx),
        .hist_i        (hist_rd),
        .btb_pc_o      (btb_rd_pc),
        .btb_hit_i     (btb_hit),
        .btb_target_i  (btb_target),
        .ctr_idx_o     (ctr_rd_idx),
        .ctr_taken_i   (ctr_taken)
    );

    bp_update_stage #(
        .PC_W      (PC_W),
        .HIST_IDX_W(HIST_IDX_W),
        .HIST_W    (HIST_W)
    ) update0 (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_pc_i    (resolve_pc_i),
        .resolve_taken_i (resolve_taken_i),
        .resolve_target_i(resolve_target_i),
        .wr_en_o         (wr_en),
        .wr_pc_o         (wr_pc),
        .wr_target_o     (wr_target),
        .wr_taken_o      (wr_taken),
        .hist_wr_idx_o   (hist_wr_idx),
        .ctr_wr_idx_o    (ctr_wr_idx),
        .old_hist_i      (old_hist)
    );

endmodule

// File: branch_predictor_assertions.sv
module branch_predictor_assertions import bp_pkg::*; #(
    parameter int PC_W       = PC_W_DEFAULT,
    parameter int HIST_IDX_W = HIST_IDX_W_DEFAULT,
    parameter int HIST_W     = HIST_W_DEFAULT,
    parameter int BTB_IDX_W  = BTB_IDX_W_DEFAULT
) (
    input logic            clk_i,
    input logic            rst_i,
    input logic            lookup_valid_i,
    input logic [PC_W-1:0] lookup_pc_i,
    input logic            lookup_ready_o,
    input logic            pred_valid_o,
    input logic [PC_W-1:0] pred_pc_o,
    input logic            pred_taken_o,
    input logic [PC_W-1:0] pred_target_o,
    input logic            pred_ready_i,
    input logic            resolve_valid_i,
    input logic [PC_W-1:0] resolve_pc_i,
    input logic            resolve_taken_i,
    input logic [PC_W-1:0] resolve_target_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HDEPTH = 2 ** HIST_IDX_W;
    localparam int CDEPTH = 2 ** HIST_W;
    localparam int BDEPTH = 2 ** BTB_IDX_W;

    int err_cnt = 0;

    // Shadow tables
    logic [HIST_W-1:0] s_hist [HDEPTH];
    logic [1:0]        s_ctr  [CDEPTH];
    logic [BDEPTH-1:0] s_val;
    logic [PC_W-3:0]   s_tag  [BDEPTH];
    logic [PC_W-1:0]   s_tgt  [BDEPTH];

    logic              upd_v;
    logic [PC_W-1:0]   upd_pc;
    logic              upd_taken;
    logic [PC_W-1:0]   upd_target;
    logic [HIST_W-1:0] upd_old;

    // Expected prediction queue, at most two in flight
    logic [PC_W-1:0]   q_pc     [16];
    logic              q_taken  [16];
    logic [PC_W-1:0]   q_target [16];
    logic [3:0]        wr_ptr;
    logic [3:0]        rd_ptr;
    logic [2:0]        in_flight;

    logic              acc;
    logic              cons;
    logic [BTB_IDX_W-1:0] lk_bidx;
    logic              lk_taken;
    logic [PC_W-1:0]   lk_target;

    assign acc  = lookup_valid_i && lookup_ready_o;
    assign cons = pred_valid_o && pred_ready_i;
    assign upd_old = s_hist[upd_pc[HIST_IDX_W+1:2]];
    assign lk_bidx = lookup_pc_i[BTB_IDX_W+1:2];

    always_comb begin
        lk_taken = s_ctr[s_hist[lookup_pc_i[HIST_IDX_W+1:2]]][1] && s_val[lk_bidx]
                   && (s_tag[lk_bidx] == lookup_pc_i[PC_W-1:2]);
        lk_target = lk_taken ? s_tgt[lk_bidx] : lookup_pc_i + PC_W'(4);
    end

    always @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < HDEPTH; i++) s_hist[i] <= '0;
            for (int i = 0; i < CDEPTH; i++) s_ctr[i] <= 2'b00;
            s_val <= '0;
            upd_v <= 1'b0;
        end else begin
            if (upd_v) begin
                s_hist[upd_pc[HIST_IDX_W+1:2]] <= {upd_old[HIST_W-2:0], upd_taken};
                if (upd_taken && s_ctr[upd_old] != 2'b11)
                    s_ctr[upd_old] <= s_ctr[upd_old] + 2'd1;
                else if (!upd_taken && s_ctr[upd_old] != 2'b00)
                    s_ctr[upd_old] <= s_ctr[upd_old] - 2'd1;
                s_val[upd_pc[BTB_IDX_W+1:2]] <= 1'b1;
                s_tag[upd_pc[BTB_IDX_W+1:2]] <= upd_pc[PC_W-1:2];
                s_tgt[upd_pc[BTB_IDX_W+1:2]] <= upd_target;
            end
            upd_v      <= resolve_valid_i;
            upd_pc     <= resolve_pc_i;
            upd_taken  <= resolve_taken_i;
            upd_target <= resolve_target_i;
        end
    end

    always @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_flight <= '0;
        end else begin
            if (acc) begin
                q_pc[wr_ptr]     <= lookup_pc_i;
                q_taken[wr_ptr]  <= lk_taken;
                q_target[wr_ptr] <= lk_target;
                wr_ptr           <= wr_ptr + 4'd1;
            end
            if (cons) rd_ptr <= rd_ptr + 4'd1;
            in_flight <= in_flight + {2'b0, acc} - {2'b0, cons};
        end
    end

    a_reset_state: assert property (@(posedge clk_i)
        !$past(rst_i) && rst_i |-> !pred_valid_o && lookup_ready_o)
        else begin err_cnt++; $error("FAILED %0t: state after reset", $time); end

    // Stage 2 free one edge after acceptance, so the PC shows two edges later
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        $past(acc, 2) && $past(!pred_valid_o || pred_ready_i)
            |-> pred_valid_o && pred_pc_o == $past(lookup_pc_i, 2))
        else begin err_cnt++; $error("FAILED %0t: prediction not ready two edges on", $time); end

    a_order: assert property (@(posedge clk_i) disable iff (!rst_i)
        pred_valid_o |-> in_flight != 3'd0 && pred_pc_o == q_pc[rd_ptr])
        else begin err_cnt++; $error("FAILED %0t: prediction PC out of order", $time); end

    a_pred: assert property (@(posedge clk_i) disable iff (!rst_i)
        pred_valid_o |-> pred_taken_o == q_taken[rd_ptr] && pred_target_o == q_target[rd_ptr])
        else begin err_cnt++; $error("FAILED %0t: wrong taken flag or target", $time); end

    a_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        pred_valid_o && !pred_ready_i |=> pred_valid_o && $stable(pred_pc_o)
            && $stable(pred_taken_o) && $stable(pred_target_o))
        else begin err_cnt++; $error("FAILED %0t: prediction changed while stalled", $time); end

    a_full: assert property (@(posedge clk_i) disable iff (!rst_i)
        in_flight == 3'd2 && !pred_ready_i |-> !lookup_ready_o)
        else begin err_cnt++; $error("FAILED %0t: ready high with both stages full", $time); end

    a_bound: assert property (@(posedge clk_i) disable iff (!rst_i)
        in_flight <= 3'd2)
        else begin err_cnt++; $error("FAILED %0t: more than two lookups in flight", $time); end

endmodule

bind branch_predictor branch_predictor_assertions #(
    .PC_W      (PC_W),
    .HIST_IDX_W(HIST_IDX_W),
    .HIST_W    (HIST_W),
    .BTB_IDX_W (BTB_IDX_W)
) chk0 (.*);

// File: branch_predictor_tb.sv
module branch_predictor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PHASE_CYCLES = 150;  // Rough sum of all phase lengths
    localparam int CYCLE_LIMIT  = 2 * PHASE_CYCLES;
    localparam logic [31:0] TPC    = 32'h0000_1230;
    localparam logic [31:0] TARGET = 32'h0000_8000;

    logic        clk_i;
    logic        rst_i;
    logic        lookup_valid_i;
    logic [31:0] lookup_pc_i;
    logic        lookup_ready_o;
    logic        pred_valid_o;
    logic [31:0] pred_pc_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        pred_ready_i;
    logic        resolve_valid_i;
    logic [31:0] resolve_pc_i;
    logic        resolve_taken_i;
    logic [31:0] resolve_target_i;

    int seed;
    int cycles;
    int tb_errors;
    int accepted;
    int consumed;
    int taken_seen;
    int taken_before;

    branch_predictor dut0 (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // Transfers counted mid-cycle, where the handshake is settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (lookup_valid_i && lookup_ready_o) accepted++;
            if (pred_valid_o && pred_ready_i) begin
                consumed++;
                if (pred_taken_o) taken_seen++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic send_lookup(input logic [31:0] pc, input bit stall);
        logic [31:0] rnd;
        logic        got;
        got = 1'b0;
        lookup_valid_i = 1'b1;
        lookup_pc_i    = pc;
        while (!got) begin
            rnd = $random(seed);
            pred_ready_i = stall ? rnd[0] : 1'b1;
            @(negedge clk_i);
            got = lookup_ready_o;
            tick();
        end
        lookup_valid_i = 1'b0;
    endtask

    task automatic drain();
        lookup_valid_i = 1'b0;
        pred_ready_i   = 1'b1;
        while (accepted != consumed) tick();
    endtask

    task automatic send_resolves(input int n, input logic taken);
        resolve_valid_i  = 1'b1;
        resolve_pc_i     = TPC;
        resolve_taken_i  = taken;
        resolve_target_i = TARGET;
        repeat (n) tick();
        resolve_valid_i = 1'b0;
    endtask

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = $random(seed);
        return r & 32'hFFFF_FFFC;
    endfunction

    initial begin
        seed = 32'h61ec;
        cycles = 0;
        tb_errors = 0;
        accepted = 0;
        consumed = 0;
        taken_seen = 0;
        rst_i = 1'b0;
        lookup_valid_i = 1'b0;
        lookup_pc_i = '0;
        pred_ready_i = 1'b1;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        resolve_target_i = '0;
        repeat (5) @(posedge clk_i);
        #1 rst_i = 1'b1;
        tick();

        // Cold tables, back-to-back lookups
        repeat (8) send_lookup(random_pc(), 1'b0);
        drain();
        // Random stalls on the prediction side
        repeat (16) send_lookup(random_pc(), 1'b1);
        drain();
        tick();
        tick();

        send_resolves(16, 1'b1);
        repeat (3) tick();
        send_lookup(TPC, 1'b0);
        send_lookup(TPC ^ 32'h0000_0400, 1'b0);  // Same index, other tag
        send_lookup(random_pc(), 1'b0);
        drain();
        if (taken_seen == 0) begin
            tb_errors++;
            $display("FAILED %0t: trained branch never predicted taken", $time);
        end
        taken_before = taken_seen;
        tick();
        tick();

        send_resolves(12, 1'b0);
        repeat (3) tick();
        send_lookup(TPC, 1'b0);
        drain();
        if (taken_seen != taken_before) begin
            tb_errors++;
            $display("FAILED %0t: decayed branch still predicted taken", $time);
        end
        tick();

        $display("Errors: assertions %0d, testbench %0d", dut0.chk0.err_cnt, tb_errors);
        if (dut0.chk0.err_cnt == 0 && tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
bp_pkg.sv
bp_history_table.sv
bp_counter_table.sv
bp_target_buffer.sv
bp_lookup_stage.sv
bp_update_stage.sv
branch_predictor.sv
branch_predictor_assertions.sv
branch_predictor_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f branch_predictor.f \
    --top-module branch_predictor_tb -o sim_bp &&
out="$(./obj_dir/sim_bp)" ; printf '%s\n' "$out" ;
printf '%s\n' "$out" | grep -qx "TEST PASS" || exit 1
